// File: exe_params.svh
`ifndef EXE_PARAMS_SVH
`define EXE_PARAMS_SVH

// datapath width
`define EXE_XLEN 32

// architectural register index
`define EXE_RA_W 5

// operation fields inside the micro-op
`define EXE_ALU_OP_W 4
`define EXE_BR_OP_W 4

`endif

// File: exe_pkg.sv
`default_nettype none

`include "exe_params.svh"

package exe_pkg;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BR,
        UNIT_MUL
    } unit_e;

    typedef enum logic [`EXE_ALU_OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_e;

    // encodings follow the decoder's cond field
    typedef enum logic [`EXE_BR_OP_W-1:0] {
        BR_JIRL = 3,
        BR_B    = 4,
        BR_BL   = 5,
        BR_BEQ  = 6,
        BR_BNE  = 7,
        BR_BLT  = 8,
        BR_BGE  = 9,
        BR_BLTU = 10,
        BR_BGEU = 11
    } br_op_e;

    typedef enum logic [1:0] {
        MUL_LO,
        MULH_S,
        MULH_U
    } mul_sel_e;

    typedef struct packed {
        unit_e    unit;
        alu_op_e  alu_op;
        br_op_e   br_op;
        mul_sel_e mul_sel;
        logic     src2_imm;
    } uop_t;

    // partial products of the operand halves, plus the signed correction
    typedef struct packed {
        logic [`EXE_XLEN-1:0] hh;
        logic [`EXE_XLEN-1:0] hl;
        logic [`EXE_XLEN-1:0] lh;
        logic [`EXE_XLEN-1:0] ll;
        logic [`EXE_XLEN-1:0] adjust;
    } mul_partial_t;

endpackage

`default_nettype wire

// File: bypass_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

interface bypass_if import exe_pkg::*; ();

    logic                 mid0_en;
    logic [`EXE_RA_W-1:0] mid0_rd;
    logic [`EXE_XLEN-1:0] mid0_data;
    logic                 mid1_en;
    logic [`EXE_RA_W-1:0] mid1_rd;
    logic [`EXE_XLEN-1:0] mid1_data;
    logic                 out0_en;
    logic [`EXE_RA_W-1:0] out0_rd;
    logic [`EXE_XLEN-1:0] out0_data;
    logic                 out1_en;
    logic [`EXE_RA_W-1:0] out1_rd;
    logic [`EXE_XLEN-1:0] out1_data;
    // mid0 holds a multiply whose data is not ready yet
    logic                 mid_mul;

    modport src (
        output mid0_en, mid0_rd, mid0_data, mid1_en, mid1_rd, mid1_data,
        output out0_en, out0_rd, out0_data, out1_en, out1_rd, out1_data,
        output mid_mul
    );

    modport dst (
        input mid0_en, mid0_rd, mid0_data, mid1_en, mid1_rd, mid1_data,
        input out0_en, out0_rd, out0_data, out1_en, out1_rd, out1_data,
        input mid_mul
    );

endinterface

`default_nettype wire

// File: alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module alu import exe_pkg::*; (
    input  alu_op_e              op,
    input  logic                 src2_imm,
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    input  logic [`EXE_XLEN-1:0] imm,
    output logic [`EXE_XLEN-1:0] result
);

    logic [`EXE_XLEN-1:0] opb;
    logic [4:0]           shamt;

    assign opb   = src2_imm ? imm : b;
    assign shamt = opb[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + opb;
            ALU_SUB:  result = a - opb;
            ALU_AND:  result = a & opb;
            ALU_OR:   result = a | opb;
            ALU_XOR:  result = a ^ opb;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_SLT:  result = {{(`EXE_XLEN-1){1'b0}}, $signed(a) < $signed(opb)};
            ALU_SLTU: result = {{(`EXE_XLEN-1){1'b0}}, a < opb};
            // immediate arrives already shifted into place
            ALU_LUI:  result = imm;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module branch_unit import exe_pkg::*; (
    input  logic                 en,
    input  br_op_e               op,
    input  logic [`EXE_XLEN-1:0] pc,
    input  logic [`EXE_XLEN-1:0] imm,
    input  logic [`EXE_XLEN-1:0] sr0,
    input  logic [`EXE_XLEN-1:0] sr1,
    output logic                 taken,
    output logic [`EXE_XLEN-1:0] target,
    output logic [`EXE_XLEN-1:0] link
);

    logic cond;

    always_comb begin
        case (op)
            BR_JIRL, BR_B, BR_BL: cond = 1'b1;
            BR_BEQ:  cond = sr0 == sr1;
            BR_BNE:  cond = sr0 != sr1;
            BR_BLT:  cond = $signed(sr0) < $signed(sr1);
            BR_BGE:  cond = $signed(sr0) >= $signed(sr1);
            BR_BLTU: cond = sr0 < sr1;
            BR_BGEU: cond = sr0 >= sr1;
            default: cond = 1'b0;
        endcase
    end

    // not-taken is the prediction, so any taken branch redirects
    assign taken = en && cond;

    // register-relative for jirl, pc-relative otherwise
    assign target = (op == BR_JIRL) ? sr0 + imm : pc + imm;

    // only bl and jirl write it back
    assign link = pc + `EXE_XLEN'd4;

endmodule

`default_nettype wire

// File: mul_partial.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module mul_partial import exe_pkg::*; (
    input  mul_sel_e             sel,
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    output mul_partial_t         partial
);

    localparam int HALF = `EXE_XLEN / 2;

    logic [HALF-1:0]      a_hi;
    logic [HALF-1:0]      a_lo;
    logic [HALF-1:0]      b_hi;
    logic [HALF-1:0]      b_lo;
    logic [`EXE_XLEN-1:0] adj;

    assign a_hi = a[`EXE_XLEN-1:HALF];
    assign a_lo = a[HALF-1:0];
    assign b_hi = b[`EXE_XLEN-1:HALF];
    assign b_lo = b[HALF-1:0];

    always_comb begin
        // signed high word = unsigned high word - (a<0 ? b : 0) - (b<0 ? a : 0)
        adj = '0;
        if (sel == MULH_S) begin
            if (a[`EXE_XLEN-1]) adj = adj - b;
            if (b[`EXE_XLEN-1]) adj = adj - a;
        end
        partial.hh     = a_hi * b_hi;
        partial.hl     = a_hi * b_lo;
        partial.lh     = a_lo * b_hi;
        partial.ll     = a_lo * b_lo;
        partial.adjust = adj;
    end

endmodule

`default_nettype wire

// File: mul_sum.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module mul_sum import exe_pkg::*; (
    input  mul_sel_e             sel,
    input  mul_partial_t         partial,
    output logic [`EXE_XLEN-1:0] result
);

    localparam int HALF = `EXE_XLEN / 2;

    logic [2*`EXE_XLEN-1:0] full;

    always_comb begin
        full = {partial.hh, partial.ll}
             + ({{`EXE_XLEN{1'b0}}, partial.hl} << HALF)
             + ({{`EXE_XLEN{1'b0}}, partial.lh} << HALF)
             + {partial.adjust, {`EXE_XLEN{1'b0}}};
    end

    assign result = (sel == MUL_LO) ? full[`EXE_XLEN-1:0] : full[2*`EXE_XLEN-1:`EXE_XLEN];

endmodule

`default_nettype wire

// File: forward_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module forward_unit import exe_pkg::*; (
    bypass_if.dst                bypass,
    input  logic                 eu0_en,
    input  logic [`EXE_RA_W-1:0] eu0_rj,
    input  logic [`EXE_RA_W-1:0] eu0_rk,
    input  logic                 eu1_en,
    input  logic [`EXE_RA_W-1:0] eu1_rj,
    input  logic [`EXE_RA_W-1:0] eu1_rk,
    input  logic [`EXE_XLEN-1:0] data00,
    input  logic [`EXE_XLEN-1:0] data01,
    input  logic [`EXE_XLEN-1:0] data10,
    input  logic [`EXE_XLEN-1:0] data11,
    output logic [`EXE_XLEN-1:0] eu0_sr0,
    output logic [`EXE_XLEN-1:0] eu0_sr1,
    output logic [`EXE_XLEN-1:0] eu1_sr0,
    output logic [`EXE_XLEN-1:0] eu1_sr1,
    output logic                 stall
);

    // youngest match wins, r0 always reads the register file
    function automatic logic [`EXE_XLEN-1:0] pick(input logic [`EXE_RA_W-1:0] rs,
                                                 input logic [`EXE_XLEN-1:0] rf);
        if (rs == '0)
            return rf;
        else if (bypass.mid1_en && bypass.mid1_rd == rs)
            return bypass.mid1_data;
        else if (bypass.mid0_en && bypass.mid0_rd == rs)
            return bypass.mid0_data;
        else if (bypass.out1_en && bypass.out1_rd == rs)
            return bypass.out1_data;
        else if (bypass.out0_en && bypass.out0_rd == rs)
            return bypass.out0_data;
        return rf;
    endfunction

    function automatic logic mid0_hit(input logic [`EXE_RA_W-1:0] rs);
        return rs != '0 && bypass.mid0_en && bypass.mid0_rd == rs;
    endfunction

    assign eu0_sr0 = pick(eu0_rj, data00);
    assign eu0_sr1 = pick(eu0_rk, data01);
    assign eu1_sr0 = pick(eu1_rj, data10);
    assign eu1_sr1 = pick(eu1_rk, data11);

    // product only exists after the out register
    assign stall = bypass.mid_mul &&
                   ((eu0_en && (mid0_hit(eu0_rj) || mid0_hit(eu0_rk))) ||
                    (eu1_en && (mid0_hit(eu1_rj) || mid0_hit(eu1_rk))));

endmodule

`default_nettype wire

// File: exe_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module exe_pipe import exe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    // lane 0
    input  logic                 eu0_en,
    input  unit_e                eu0_unit,
    input  logic [`EXE_RA_W-1:0] eu0_rd,
    input  logic [`EXE_XLEN-1:0] eu0_alu_result,
    input  logic                 br_taken,
    input  logic [`EXE_XLEN-1:0] br_target,
    input  logic [`EXE_XLEN-1:0] br_link,
    input  mul_partial_t         partial,
    input  mul_sel_e             mul_sel,
    // lane 1
    input  logic                 eu1_en,
    input  logic [`EXE_RA_W-1:0] eu1_rd,
    input  logic [`EXE_XLEN-1:0] eu1_alu_result,
    input  logic [`EXE_XLEN-1:0] mul_result,
    bypass_if.src                bypass,
    output mul_partial_t         mul_partial_q,
    output mul_sel_e             mul_sel_q,
    output logic                 en_out0,
    output logic [`EXE_RA_W-1:0] addr_out0,
    output logic [`EXE_XLEN-1:0] data_out0,
    output logic                 en_out1,
    output logic [`EXE_RA_W-1:0] addr_out1,
    output logic [`EXE_XLEN-1:0] data_out1,
    output logic                 flush,
    output logic [`EXE_XLEN-1:0] correct_pc
);

    logic                 mid0_en;
    logic [`EXE_RA_W-1:0] mid0_rd;
    logic [`EXE_XLEN-1:0] mid0_data;
    logic                 mid_mul;
    logic                 mid1_en;
    logic [`EXE_RA_W-1:0] mid1_rd;
    logic [`EXE_XLEN-1:0] mid1_data;
    logic                 is_br;
    logic                 redirect;

    assign is_br = eu0_unit == UNIT_BR;

    // a branch held by stall or squashed by flush must not redirect
    assign redirect = eu0_en && is_br && br_taken && !stall && !flush;

    // issue -> mid
    always_ff @(posedge clk) begin
        if (!rst_n || stall || flush) begin
            mid0_en <= 1'b0;
            mid_mul <= 1'b0;
            mid1_en <= 1'b0;
        end else begin
            // conditional branches carry rd 0 and write nothing
            mid0_en <= eu0_en && !(is_br && eu0_rd == '0);
            mid_mul <= eu0_en && eu0_unit == UNIT_MUL;
            mid1_en <= eu1_en;
        end
    end

    always_ff @(posedge clk) begin
        mid0_rd       <= eu0_rd;
        mid0_data     <= is_br ? br_link : eu0_alu_result;
        mul_partial_q <= partial;
        mul_sel_q     <= mul_sel;
        mid1_rd       <= eu1_rd;
        mid1_data     <= eu1_alu_result;
    end

    // one-cycle redirect
    always_ff @(posedge clk) begin
        if (!rst_n)
            flush <= 1'b0;
        else
            flush <= redirect;
    end

    always_ff @(posedge clk) begin
        if (redirect)
            correct_pc <= br_target;
    end

    // mid -> out, never held
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_out0 <= 1'b0;
            en_out1 <= 1'b0;
        end else begin
            en_out0 <= mid0_en;
            en_out1 <= mid1_en;
        end
    end

    always_ff @(posedge clk) begin
        addr_out0 <= mid0_rd;
        data_out0 <= mid_mul ? mul_result : mid0_data;
        addr_out1 <= mid1_rd;
        data_out1 <= mid1_data;
    end

    assign bypass.mid0_en   = mid0_en;
    assign bypass.mid0_rd   = mid0_rd;
    assign bypass.mid0_data = mid0_data;
    assign bypass.mid1_en   = mid1_en;
    assign bypass.mid1_rd   = mid1_rd;
    assign bypass.mid1_data = mid1_data;
    assign bypass.out0_en   = en_out0;
    assign bypass.out0_rd   = addr_out0;
    assign bypass.out0_data = data_out0;
    assign bypass.out1_en   = en_out1;
    assign bypass.out1_rd   = addr_out1;
    assign bypass.out1_data = data_out1;
    assign bypass.mid_mul   = mid_mul;

endmodule

`default_nettype wire

// File: exe_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module exe_top import exe_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 eu0_en,
    input  uop_t                 eu0_uop,
    input  logic [`EXE_RA_W-1:0] eu0_rd,
    input  logic [`EXE_RA_W-1:0] eu0_rj,
    input  logic [`EXE_RA_W-1:0] eu0_rk,
    input  logic [`EXE_XLEN-1:0] eu0_imm,
    input  logic [`EXE_XLEN-1:0] eu0_pc,
    input  logic [`EXE_XLEN-1:0] data00,
    input  logic [`EXE_XLEN-1:0] data01,
    input  logic                 eu1_en,
    input  uop_t                 eu1_uop,
    input  logic [`EXE_RA_W-1:0] eu1_rd,
    input  logic [`EXE_RA_W-1:0] eu1_rj,
    input  logic [`EXE_RA_W-1:0] eu1_rk,
    input  logic [`EXE_XLEN-1:0] eu1_imm,
    input  logic [`EXE_XLEN-1:0] data10,
    input  logic [`EXE_XLEN-1:0] data11,
    output logic                 en_out0,
    output logic [`EXE_RA_W-1:0] addr_out0,
    output logic [`EXE_XLEN-1:0] data_out0,
    output logic                 en_out1,
    output logic [`EXE_RA_W-1:0] addr_out1,
    output logic [`EXE_XLEN-1:0] data_out1,
    output logic                 stall,
    output logic                 flush,
    output logic [`EXE_XLEN-1:0] correct_pc
);

    logic [`EXE_XLEN-1:0] eu0_sr0;
    logic [`EXE_XLEN-1:0] eu0_sr1;
    logic [`EXE_XLEN-1:0] eu1_sr0;
    logic [`EXE_XLEN-1:0] eu1_sr1;
    logic [`EXE_XLEN-1:0] eu0_alu_result;
    logic [`EXE_XLEN-1:0] eu1_alu_result;
    logic                 br_taken;
    logic [`EXE_XLEN-1:0] br_target;
    logic [`EXE_XLEN-1:0] br_link;
    mul_partial_t         partial;
    mul_partial_t         partial_q;
    mul_sel_e             sel_q;
    logic [`EXE_XLEN-1:0] mul_result;

    bypass_if bypass ();

    forward_unit u_forward (
        .bypass  (bypass),
        .eu0_en  (eu0_en),
        .eu0_rj  (eu0_rj),
        .eu0_rk  (eu0_rk),
        .eu1_en  (eu1_en),
        .eu1_rj  (eu1_rj),
        .eu1_rk  (eu1_rk),
        .data00  (data00),
        .data01  (data01),
        .data10  (data10),
        .data11  (data11),
        .eu0_sr0 (eu0_sr0),
        .eu0_sr1 (eu0_sr1),
        .eu1_sr0 (eu1_sr0),
        .eu1_sr1 (eu1_sr1),
        .stall   (stall)
    );

    alu u_alu0 (
        .op       (eu0_uop.alu_op),
        .src2_imm (eu0_uop.src2_imm),
        .a        (eu0_sr0),
        .b        (eu0_sr1),
        .imm      (eu0_imm),
        .result   (eu0_alu_result)
    );

    alu u_alu1 (
        .op       (eu1_uop.alu_op),
        .src2_imm (eu1_uop.src2_imm),
        .a        (eu1_sr0),
        .b        (eu1_sr1),
        .imm      (eu1_imm),
        .result   (eu1_alu_result)
    );

    branch_unit u_branch (
        .en     (eu0_en),
        .op     (eu0_uop.br_op),
        .pc     (eu0_pc),
        .imm    (eu0_imm),
        .sr0    (eu0_sr0),
        .sr1    (eu0_sr1),
        .taken  (br_taken),
        .target (br_target),
        .link   (br_link)
    );

    mul_partial u_mul_partial (
        .sel     (eu0_uop.mul_sel),
        .a       (eu0_sr0),
        .b       (eu0_sr1),
        .partial (partial)
    );

    mul_sum u_mul_sum (
        .sel     (sel_q),
        .partial (partial_q),
        .result  (mul_result)
    );

    exe_pipe u_pipe (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .eu0_en         (eu0_en),
        .eu0_unit       (eu0_uop.unit),
        .eu0_rd         (eu0_rd),
        .eu0_alu_result (eu0_alu_result),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .br_link        (br_link),
        .partial        (partial),
        .mul_sel        (eu0_uop.mul_sel),
        .eu1_en         (eu1_en),
        .eu1_rd         (eu1_rd),
        .eu1_alu_result (eu1_alu_result),
        .mul_result     (mul_result),
        .bypass         (bypass),
        .mul_partial_q  (partial_q),
        .mul_sel_q      (sel_q),
        .en_out0        (en_out0),
        .addr_out0      (addr_out0),
        .data_out0      (data_out0),
        .en_out1        (en_out1),
        .addr_out1      (addr_out1),
        .data_out1      (data_out1),
        .flush          (flush),
        .correct_pc     (correct_pc)
    );

endmodule

`default_nettype wire

// File: tb_exe.sv
`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module tb_exe import exe_pkg::*; ();

    localparam int N_ALU       = 60;
    localparam int N_MUL       = 40;
    localparam int N_STALL     = 30;
    localparam int N_BR        = 60;
    localparam int TOTAL_OPS   = 2 * (N_ALU + N_MUL + N_STALL + N_BR);
    localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + 50;

    typedef struct packed {
        logic [`EXE_RA_W-1:0] rd;
        logic [`EXE_XLEN-1:0] data;
    } wb_t;

    logic                 clk;
    logic                 rst_n;
    logic                 eu0_en;
    uop_t                 eu0_uop;
    logic [`EXE_RA_W-1:0] eu0_rd;
    logic [`EXE_RA_W-1:0] eu0_rj;
    logic [`EXE_RA_W-1:0] eu0_rk;
    logic [`EXE_XLEN-1:0] eu0_imm;
    logic [`EXE_XLEN-1:0] eu0_pc;
    logic [`EXE_XLEN-1:0] data00;
    logic [`EXE_XLEN-1:0] data01;
    logic                 eu1_en;
    uop_t                 eu1_uop;
    logic [`EXE_RA_W-1:0] eu1_rd;
    logic [`EXE_RA_W-1:0] eu1_rj;
    logic [`EXE_RA_W-1:0] eu1_rk;
    logic [`EXE_XLEN-1:0] eu1_imm;
    logic [`EXE_XLEN-1:0] data10;
    logic [`EXE_XLEN-1:0] data11;
    logic                 en_out0;
    logic [`EXE_RA_W-1:0] addr_out0;
    logic [`EXE_XLEN-1:0] data_out0;
    logic                 en_out1;
    logic [`EXE_RA_W-1:0] addr_out1;
    logic [`EXE_XLEN-1:0] data_out1;
    logic                 stall;
    logic                 flush;
    logic [`EXE_XLEN-1:0] correct_pc;

    // pair being presented by the issuer
    logic                 p0_en;
    uop_t                 p0_uop;
    logic [`EXE_RA_W-1:0] p0_rd;
    logic [`EXE_RA_W-1:0] p0_rj;
    logic [`EXE_RA_W-1:0] p0_rk;
    logic [`EXE_XLEN-1:0] p0_imm;
    logic [`EXE_XLEN-1:0] p0_pc;
    logic                 p1_en;
    uop_t                 p1_uop;
    logic [`EXE_RA_W-1:0] p1_rd;
    logic [`EXE_RA_W-1:0] p1_rj;
    logic [`EXE_RA_W-1:0] p1_rk;
    logic [`EXE_XLEN-1:0] p1_imm;

    // issuer's view is fed only by write-back
    logic [`EXE_XLEN-1:0] rf_view [0:31];
    logic [`EXE_XLEN-1:0] arch_rf [0:31];
    wb_t                  exp0 [$];
    wb_t                  exp1 [$];

    logic                 mid_mul_valid;
    logic [`EXE_RA_W-1:0] mid_mul_rd;
    logic                 exp_flush;
    logic [`EXE_XLEN-1:0] exp_target;
    logic                 saw_stall;
    int                   discards;
    int                   errors;
    int                   test_errs;
    int                   tests_run;
    int                   tests_failed;
    int                   cycles;
    string                test_name;

    exe_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [`EXE_XLEN-1:0] alu_model(alu_op_e op, logic [`EXE_XLEN-1:0] a,
                                                      logic [`EXE_XLEN-1:0] b,
                                                      logic [`EXE_XLEN-1:0] imm);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            ALU_SLTU: return (a < b) ? 1 : 0;
            ALU_LUI:  return imm;
            default:  return '0;
        endcase
    endfunction

    // reference products at full double width
    function automatic logic [`EXE_XLEN-1:0] mul_model(mul_sel_e sel, logic [`EXE_XLEN-1:0] a,
                                                      logic [`EXE_XLEN-1:0] b);
        logic signed [2*`EXE_XLEN-1:0] sp;
        logic [2*`EXE_XLEN-1:0]        up;
        sp = $signed({{`EXE_XLEN{a[`EXE_XLEN-1]}}, a}) * $signed({{`EXE_XLEN{b[`EXE_XLEN-1]}}, b});
        up = {{`EXE_XLEN{1'b0}}, a} * {{`EXE_XLEN{1'b0}}, b};
        case (sel)
            MULH_S:  return sp[2*`EXE_XLEN-1:`EXE_XLEN];
            MULH_U:  return up[2*`EXE_XLEN-1:`EXE_XLEN];
            default: return up[`EXE_XLEN-1:0];
        endcase
    endfunction

    function automatic logic branch_model(br_op_e op, logic [`EXE_XLEN-1:0] a,
                                          logic [`EXE_XLEN-1:0] b);
        case (op)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic mul_hit(logic [`EXE_RA_W-1:0] r);
        return r != 0 && r == mid_mul_rd;
    endfunction

    task automatic set_lane0_alu();
        p0_en            = ($urandom_range(7, 0) != 0);
        p0_uop           = '0;
        p0_uop.unit      = UNIT_ALU;
        p0_uop.alu_op    = alu_op_e'($urandom_range(10, 0));
        p0_uop.br_op     = BR_BEQ;
        p0_uop.src2_imm  = $urandom_range(1, 0);
        p0_rd            = $urandom_range(7, 1);
        p0_rj            = $urandom_range(7, 0);
        p0_rk            = $urandom_range(7, 0);
        p0_imm           = $urandom;
        p0_pc            = '0;
    endtask

    task automatic set_lane0_mul();
        set_lane0_alu();
        p0_en          = 1'b1;
        p0_uop.unit    = UNIT_MUL;
        p0_uop.mul_sel = mul_sel_e'($urandom_range(2, 0));
    endtask

    task automatic set_lane0_branch(input br_op_e op);
        set_lane0_alu();
        p0_en        = 1'b1;
        p0_uop.unit  = UNIT_BR;
        p0_uop.br_op = op;
        p0_pc        = $urandom & 32'hffff_fffc;
        p0_imm       = $urandom_range(255, 0) * 4 - 512;
        if (op == BR_BL)
            p0_rd = 1;
        else if (op != BR_JIRL)
            p0_rd = 0;
        // equal operands now and then
        if ($urandom_range(2, 0) == 0)
            p0_rk = p0_rj;
    endtask

    task automatic set_lane1();
        p1_en           = ($urandom_range(3, 0) != 0);
        p1_uop          = '0;
        p1_uop.unit     = UNIT_ALU;
        p1_uop.br_op    = BR_BEQ;
        p1_uop.alu_op   = alu_op_e'($urandom_range(10, 0));
        if ($urandom_range(3, 0) == 0)
            p1_uop.alu_op = ALU_LUI;
        p1_uop.src2_imm = $urandom_range(1, 0);
        p1_imm          = $urandom;
        do p1_rd = $urandom_range(7, 1); while (p1_rd == p0_rd);
        do p1_rj = $urandom_range(7, 0); while (p0_rd != 0 && p1_rj == p0_rd);
        do p1_rk = $urandom_range(7, 0); while (p0_rd != 0 && p1_rk == p0_rd);
    endtask

    task automatic accept_pair();
        logic [`EXE_XLEN-1:0] a0;
        logic [`EXE_XLEN-1:0] b0;
        logic [`EXE_XLEN-1:0] a1;
        logic [`EXE_XLEN-1:0] b1;
        logic [`EXE_XLEN-1:0] r0v;
        logic [`EXE_XLEN-1:0] r1v;
        logic                 w0;
        logic                 taken;
        a0    = arch_rf[p0_rj];
        b0    = arch_rf[p0_rk];
        a1    = arch_rf[p1_rj];
        b1    = arch_rf[p1_rk];
        w0    = 1'b0;
        taken = 1'b0;
        r0v   = '0;
        r1v   = alu_model(p1_uop.alu_op, a1, p1_uop.src2_imm ? p1_imm : b1, p1_imm);
        if (p0_en) begin
            case (p0_uop.unit)
                UNIT_MUL: begin
                    r0v = mul_model(p0_uop.mul_sel, a0, b0);
                    w0  = 1'b1;
                end
                UNIT_BR: begin
                    taken      = branch_model(p0_uop.br_op, a0, b0);
                    exp_target = ((p0_uop.br_op == BR_JIRL) ? a0 : p0_pc) + p0_imm;
                    r0v        = p0_pc + 4;
                    w0         = (p0_rd != 0);
                end
                default: begin
                    r0v = alu_model(p0_uop.alu_op, a0, p0_uop.src2_imm ? p0_imm : b0, p0_imm);
                    w0  = 1'b1;
                end
            endcase
        end
        if (w0) begin
            exp0.push_back({p0_rd, r0v});
            arch_rf[p0_rd] = r0v;
        end
        if (p1_en) begin
            exp1.push_back({p1_rd, r1v});
            arch_rf[p1_rd] = r1v;
        end
        mid_mul_valid = p0_en && p0_uop.unit == UNIT_MUL;
        mid_mul_rd    = p0_rd;
        exp_flush     = taken;
    endtask

    // present the pair until it is taken or dropped by a flush
    task automatic issue_pair();
        logic done;
        logic exp_stall;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #2;
            eu0_en  = p0_en;
            eu0_uop = p0_uop;
            eu0_rd  = p0_rd;
            eu0_rj  = p0_rj;
            eu0_rk  = p0_rk;
            eu0_imm = p0_imm;
            eu0_pc  = p0_pc;
            eu1_en  = p1_en;
            eu1_uop = p1_uop;
            eu1_rd  = p1_rd;
            eu1_rj  = p1_rj;
            eu1_rk  = p1_rk;
            eu1_imm = p1_imm;
            data00  = rf_view[p0_rj];
            data01  = rf_view[p0_rk];
            data10  = rf_view[p1_rj];
            data11  = rf_view[p1_rk];
            #1;
            exp_stall = mid_mul_valid &&
                        ((p0_en && (mul_hit(p0_rj) || mul_hit(p0_rk))) ||
                         (p1_en && (mul_hit(p1_rj) || mul_hit(p1_rk))));
            assert (stall === exp_stall) else begin
                errors++;
                $display("mismatch in %s: stall expected %b, actual %b",
                         test_name, exp_stall, stall);
            end
            assert (flush === exp_flush) else begin
                errors++;
                $display("mismatch in %s: flush expected %b, actual %b",
                         test_name, exp_flush, flush);
            end
            if (flush) begin
                assert (correct_pc === exp_target) else begin
                    errors++;
                    $display("mismatch in %s: correct_pc expected %h, actual %h",
                             test_name, exp_target, correct_pc);
                end
                discards++;
                mid_mul_valid = 1'b0;
                exp_flush     = 1'b0;
                done          = 1'b1;
            end else if (stall) begin
                saw_stall     = 1'b1;
                mid_mul_valid = 1'b0;
                exp_flush     = 1'b0;
            end else begin
                accept_pair();
                done = 1'b1;
            end
        end
    endtask

    task automatic idle_pair();
        p0_en = 1'b0;
        p1_en = 1'b0;
        issue_pair();
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = errors;
        saw_stall = 1'b0;
        discards  = 0;
    endtask

    task automatic end_test();
        while (exp0.size() > 0 || exp1.size() > 0)
            idle_pair();
        repeat (2) idle_pair();
        for (int i = 1; i < 8; i++) begin
            assert (rf_view[i] === arch_rf[i]) else begin
                errors++;
                $display("mismatch in %s: register r%0d expected %h, actual %h",
                         test_name, i, arch_rf[i], rf_view[i]);
            end
        end
        tests_run++;
        if (errors != test_errs)
            tests_failed++;
        $display("%-14s %s, %0d errors", test_name,
                 (errors == test_errs) ? "ok" : "FAILED", errors - test_errs);
    endtask

    task automatic writeback_check(input int lane, input logic en,
                                   input logic [`EXE_RA_W-1:0] addr,
                                   input logic [`EXE_XLEN-1:0] data);
        wb_t  exp;
        logic have;
        if (en) begin
            have = (lane == 0) ? exp0.size() > 0 : exp1.size() > 0;
            assert (have) else begin
                errors++;
                $display("%s: lane %0d wrote r%0d when no result was expected",
                         test_name, lane, addr);
            end
            if (have) begin
                exp = (lane == 0) ? exp0.pop_front() : exp1.pop_front();
                assert (addr === exp.rd && data === exp.data) else begin
                    errors++;
                    $display("mismatch in %s: lane %0d expected r%0d=%h, actual r%0d=%h",
                             test_name, lane, exp.rd, exp.data, addr, data);
                end
            end
            if (addr != 0)
                rf_view[addr] = data;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            writeback_check(0, en_out0, addr_out0, data_out0);
            writeback_check(1, en_out1, addr_out1, data_out1);
        end
    end

    initial begin
        void'($urandom(32'h2735_bc0c));
        rst_n   = 1'b0;
        eu0_en  = 1'b0;
        eu0_uop = '0;
        eu0_rd  = '0;
        eu0_rj  = '0;
        eu0_rk  = '0;
        eu0_imm = '0;
        eu0_pc  = '0;
        data00  = '0;
        data01  = '0;
        eu1_en  = 1'b0;
        eu1_uop = '0;
        eu1_rd  = '0;
        eu1_rj  = '0;
        eu1_rk  = '0;
        eu1_imm = '0;
        data10  = '0;
        data11  = '0;
        p0_rd   = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        mid_mul_valid = 1'b0;
        mid_mul_rd    = '0;
        exp_flush     = 1'b0;
        exp_target    = '0;
        rf_view[0] = '0;
        arch_rf[0] = '0;
        for (int i = 1; i < 32; i++) begin
            rf_view[i] = $urandom;
            arch_rf[i] = rf_view[i];
        end

        start_test("reset_state");
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #2;
            if (i == 2)
                rst_n = 1'b1;
            @(negedge clk);
            assert (!en_out0 && !en_out1 && !flush && !stall) else begin
                errors++;
                $display("%s: outputs active around reset (en %b%b flush %b stall %b)",
                         test_name, en_out0, en_out1, flush, stall);
            end
        end
        end_test();

        start_test("alu_pairs");
        for (int i = 0; i < N_ALU; i++) begin
            set_lane0_alu();
            set_lane1();
            issue_pair();
        end
        end_test();

        start_test("mul_ops");
        for (int i = 0; i < N_MUL; i++) begin
            set_lane0_mul();
            set_lane1();
            issue_pair();
        end
        end_test();

        start_test("mul_use_stall");
        for (int i = 0; i < N_STALL; i++) begin
            if (i % 2 == 0) begin
                set_lane0_mul();
            end else begin
                set_lane0_alu();
                p0_en = 1'b1;
                p0_rj = mid_mul_rd;
            end
            set_lane1();
            issue_pair();
        end
        assert (saw_stall) else begin
            errors++;
            $display("%s: no stall occurred", test_name);
        end
        end_test();

        start_test("branches");
        for (int i = 0; i < N_BR; i++) begin
            if (i % 2 == 0)
                set_lane0_branch(br_op_e'(BR_JIRL + (i / 2) % 9));
            else
                set_lane0_alu();
            set_lane1();
            issue_pair();
        end
        assert (discards > 0) else begin
            errors++;
            $display("%s: no branch was taken", test_name);
        end
        end_test();

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: exe.f
+incdir+.
exe_pkg.sv
bypass_if.sv
alu.sv
branch_unit.sv
mul_partial.sv
mul_sum.sv
forward_unit.sv
exe_pipe.sv
exe_top.sv
tb_exe.sv
